// ==== ddr3_phy_defines.svh ====
// Shared sizes for the DDR3 PHY and its DFI side
// One DFI word carries two DQ beats, so DFI widths are twice the pin widths
// Legal read latency is 0 to PHY_RD_SHIFT_W-1

`ifndef DDR3_PHY_DEFINES_SVH
`define DDR3_PHY_DEFINES_SVH

// ---------------------------------------------------------------------------
// DDR3 pin widths
// ---------------------------------------------------------------------------
`define DDR3_DQ_W            16
`define DDR3_DM_W            2
`define DDR3_DQS_W           2
`define DDR3_ADDR_W          15
`define DDR3_BA_W            3

// DFI side, two beats per word
`define DFI_DATA_W           32
`define DFI_MASK_W           4

// ---------------------------------------------------------------------------
// Read latency configuration
// ---------------------------------------------------------------------------
`define PHY_RDLAT_DEFAULT    4
// Field position inside the 32-bit config word
`define PHY_CFG_RDLAT_LSB    8
`define PHY_CFG_RDLAT_MSB    11
`define PHY_RD_SHIFT_W       12

`endif

// ==== dfi_pkg.sv ====
// Types seen by the memory controller on the DFI side
// Data word layout is {first beat, second beat}

`default_nettype none

`include "ddr3_phy_defines.svh"

package dfi_pkg;

    typedef logic [`DDR3_ADDR_W-1:0] dfi_addr_t;
    typedef logic [`DDR3_BA_W-1:0]   dfi_bank_t;

    // Upper half goes out first
    typedef logic [`DFI_DATA_W-1:0]  dfi_data_t;
    typedef logic [`DFI_MASK_W-1:0]  dfi_mask_t;

    // Config word and the read latency field taken from it
    typedef logic [31:0] phy_cfg_t;
    typedef logic [`PHY_CFG_RDLAT_MSB-`PHY_CFG_RDLAT_LSB:0] rd_lat_t;

endpackage

`default_nettype wire

// ==== ddr3_pkg.sv ====
// Types for the DDR3 pin side of the PHY
// One value of each type is a single beat on the pins

`default_nettype none

`include "ddr3_phy_defines.svh"

package ddr3_pkg;

    // Data pins
    typedef logic [`DDR3_DQ_W-1:0]  dq_t;

    // Data mask, one bit per byte lane
    typedef logic [`DDR3_DM_W-1:0]  dm_t;

    // Strobes
    typedef logic [`DDR3_DQS_W-1:0] dqs_t;

endpackage

`default_nettype wire

// ==== ddr3_cmd_path.sv ====
// Command and address pins, one register stage
// All pins are 0 during and after reset, the active-low ones too,
// so the controller must drive reset_n and cs_n before use

`timescale 1ns/10ps
`default_nettype none

module ddr3_cmd_path
(
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire logic               dfi_cke_i,
    input  wire logic               dfi_reset_n_i,
    input  wire logic               dfi_ras_n_i,
    input  wire logic               dfi_cas_n_i,
    input  wire logic               dfi_we_n_i,
    input  wire logic               dfi_cs_n_i,
    input  wire logic               dfi_odt_i,
    input  wire dfi_pkg::dfi_bank_t dfi_bank_i,
    input  wire dfi_pkg::dfi_addr_t dfi_address_i,
    output logic                    ddr3_cke_o,
    output logic                    ddr3_reset_n_o,
    output logic                    ddr3_ras_n_o,
    output logic                    ddr3_cas_n_o,
    output logic                    ddr3_we_n_o,
    output logic                    ddr3_cs_n_o,
    output logic                    ddr3_odt_o,
    output dfi_pkg::dfi_bank_t      ddr3_ba_o,
    output dfi_pkg::dfi_addr_t      ddr3_addr_o
);

    // Pins come straight from flops so they switch on the clock edge
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            ddr3_cke_o     <= 1'b0;
            ddr3_reset_n_o <= 1'b0;
            ddr3_ras_n_o   <= 1'b0;
            ddr3_cas_n_o   <= 1'b0;
            ddr3_we_n_o    <= 1'b0;
            ddr3_cs_n_o    <= 1'b0;
            ddr3_odt_o     <= 1'b0;
            ddr3_ba_o      <= '0;
            ddr3_addr_o    <= '0;
        end
        else
        begin
            ddr3_cke_o     <= dfi_cke_i;
            ddr3_reset_n_o <= dfi_reset_n_i;
            ddr3_ras_n_o   <= dfi_ras_n_i;
            ddr3_cas_n_o   <= dfi_cas_n_i;
            ddr3_we_n_o    <= dfi_we_n_i;
            ddr3_cs_n_o    <= dfi_cs_n_i;
            ddr3_odt_o     <= dfi_odt_i;
            ddr3_ba_o      <= dfi_bank_i;
            ddr3_addr_o    <= dfi_address_i;
        end
    end

endmodule

`default_nettype wire

// ==== ddr_out_lane.sv ====
// Double-data-rate output for one payload type
// Both beats load at the rising edge; first beat out while clk_i is high,
// second beat while it is low. Output mux is on the clock itself

`timescale 1ns/10ps
`default_nettype none

module ddr_out_lane
#(
    parameter type lane_t = logic
)
(
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    input  wire lane_t first_i,
    input  wire lane_t second_i,
    output lane_t      pin_o
);

    lane_t first_q;
    lane_t second_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            first_q  <= '0;
            second_q <= '0;
        end
        else
        begin
            first_q  <= first_i;
            second_q <= second_i;
        end
    end

    // High phase shows the first beat
    assign pin_o = clk_i ? first_q : second_q;

endmodule

`default_nettype wire

// ==== ddr3_write_path.sv ====
// Write data, mask and the DQ/DQS output enable
// Word staged at edge N is on the pins during the cycle after edge N+1
// Enables are high for k+1 cycles for a k-word burst, from edge N+2

`timescale 1ns/10ps
`default_nettype none

`include "ddr3_phy_defines.svh"

module ddr3_write_path
(
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire dfi_pkg::dfi_data_t dfi_wrdata_i,
    input  wire dfi_pkg::dfi_mask_t dfi_wrdata_mask_i,
    input  wire logic               dfi_wrdata_en_i,
    output ddr3_pkg::dq_t           dq_o,
    output ddr3_pkg::dm_t           dm_o,
    output logic                    dq_oe_o,
    output logic                    dqs_oe_o
);

    dfi_pkg::dfi_data_t wrdata_q;
    dfi_pkg::dfi_mask_t wrmask_q;
    logic               wr_en_q0;
    logic               wr_en_q1;
    logic               wr_en_q2;
    logic               oe_q;

    // ------------------------------------------------------------------------
    // Data and mask staging
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wrdata_q <= '0;
            wrmask_q <= '0;
        end
        else
        begin
            wrdata_q <= dfi_wrdata_i;
            wrmask_q <= dfi_wrdata_mask_i;
        end
    end

    // Upper half is the first beat
    ddr_out_lane #(.lane_t(ddr3_pkg::dq_t)) u_dq_lane
    (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .first_i  (wrdata_q[`DFI_DATA_W-1 -: `DDR3_DQ_W]),
        .second_i (wrdata_q[`DDR3_DQ_W-1:0]),
        .pin_o    (dq_o)
    );

    ddr_out_lane #(.lane_t(ddr3_pkg::dm_t)) u_dm_lane
    (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .first_i  (wrmask_q[`DFI_MASK_W-1 -: `DDR3_DM_W]),
        .second_i (wrmask_q[`DDR3_DM_W-1:0]),
        .pin_o    (dm_o)
    );

    // ------------------------------------------------------------------------
    // Output enable sequence
    // ------------------------------------------------------------------------
    // Set from stage 1, held until stage 2 drains, one extra cycle of drive
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_en_q0 <= 1'b0;
            wr_en_q1 <= 1'b0;
            wr_en_q2 <= 1'b0;
            oe_q     <= 1'b0;
        end
        else
        begin
            wr_en_q0 <= dfi_wrdata_en_i;
            wr_en_q1 <= wr_en_q0;
            wr_en_q2 <= wr_en_q1;
            if (wr_en_q1)
                oe_q <= 1'b1;
            else if (!wr_en_q2)
                oe_q <= 1'b0;
        end
    end

    // DQ and DQS pads share one enable
    assign dq_oe_o  = oe_q;
    assign dqs_oe_o = oe_q;

endmodule

`default_nettype wire

// ==== ddr3_read_path.sv ====
// Read capture from the DQ input pins
// No delay tuning; dq_i must be stable around both clk_i edges
// Result word is {rising-edge beat, preceding falling-edge beat}

`timescale 1ns/10ps
`default_nettype none

module ddr3_read_path
(
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire ddr3_pkg::dq_t      dq_i,
    output dfi_pkg::dfi_data_t      dfi_rddata_o
);

    ddr3_pkg::dq_t fall_q;

    // ------------------------------------------------------------------------
    // Falling edge capture
    // ------------------------------------------------------------------------
    // Second beat of the word
    always_ff @(negedge clk_i)
    begin
        fall_q <= dq_i;
    end

    // ------------------------------------------------------------------------
    // Rising edge assembly
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            dfi_rddata_o <= '0;
        end
        else
        begin
            dfi_rddata_o <= {dq_i, fall_q};
        end
    end

endmodule

`default_nettype wire

// ==== ddr3_rd_valid_sched.sv ====
// Read valid timing from the programmable read latency
// Latency loads from cfg_i bits 11:8 on cfg_valid_i; values above 11
// are not scheduled. Reads already in flight keep their slot

`timescale 1ns/10ps
`default_nettype none

`include "ddr3_phy_defines.svh"

module ddr3_rd_valid_sched
(
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic              cfg_valid_i,
    input  wire dfi_pkg::phy_cfg_t cfg_i,
    input  wire logic              dfi_rddata_en_i,
    output logic                   dfi_rddata_valid_o
);

    dfi_pkg::rd_lat_t            rd_lat_q;
    logic [`PHY_RD_SHIFT_W-1:0]  sched_q;
    logic [`PHY_RD_SHIFT_W-1:0]  sched_d;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            rd_lat_q <= dfi_pkg::rd_lat_t'(`PHY_RDLAT_DEFAULT);
        else if (cfg_valid_i)
            rd_lat_q <= cfg_i[`PHY_CFG_RDLAT_MSB:`PHY_CFG_RDLAT_LSB];
    end

    // Shift toward stage 0 and drop the new read in at stage rd_lat_q
    always_comb
    begin
        sched_d = {1'b0, sched_q[`PHY_RD_SHIFT_W-1:1]};
        for (int i = 0; i < `PHY_RD_SHIFT_W; i++)
        begin
            if (rd_lat_q == dfi_pkg::rd_lat_t'(i))
                sched_d[i] = sched_d[i] | dfi_rddata_en_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            sched_q <= '0;
        else
            sched_q <= sched_d;
    end

    assign dfi_rddata_valid_o = sched_q[0];

endmodule

`default_nettype wire

// ==== ddr3_phy_top.sv ====
// DDR3 PHY top, DFI controller side to DDR3 pins
// Each bidirectional pad is split into output, enable and input ports;
// the pad ring outside combines them. clk_ddr_i is clk_i shifted 90 degrees

`timescale 1ns/10ps
`default_nettype none

module ddr3_phy_top
(
    input  wire logic               clk_i,
    input  wire logic               clk_ddr_i,
    input  wire logic               rst_i,
    // Configuration
    input  wire logic               cfg_valid_i,
    input  wire dfi_pkg::phy_cfg_t  cfg_i,
    // DFI command
    input  wire logic               dfi_cke_i,
    input  wire logic               dfi_reset_n_i,
    input  wire logic               dfi_ras_n_i,
    input  wire logic               dfi_cas_n_i,
    input  wire logic               dfi_we_n_i,
    input  wire logic               dfi_cs_n_i,
    input  wire logic               dfi_odt_i,
    input  wire dfi_pkg::dfi_bank_t dfi_bank_i,
    input  wire dfi_pkg::dfi_addr_t dfi_address_i,
    // DFI write and read
    input  wire dfi_pkg::dfi_data_t dfi_wrdata_i,
    input  wire dfi_pkg::dfi_mask_t dfi_wrdata_mask_i,
    input  wire logic               dfi_wrdata_en_i,
    input  wire logic               dfi_rddata_en_i,
    output dfi_pkg::dfi_data_t      dfi_rddata_o,
    output logic                    dfi_rddata_valid_o,
    // DDR3 pins
    output logic                    ddr3_ck_o,
    output logic                    ddr3_cke_o,
    output logic                    ddr3_reset_n_o,
    output logic                    ddr3_ras_n_o,
    output logic                    ddr3_cas_n_o,
    output logic                    ddr3_we_n_o,
    output logic                    ddr3_cs_n_o,
    output logic                    ddr3_odt_o,
    output dfi_pkg::dfi_bank_t      ddr3_ba_o,
    output dfi_pkg::dfi_addr_t      ddr3_addr_o,
    output ddr3_pkg::dq_t           dq_o,
    output ddr3_pkg::dm_t           dm_o,
    output logic                    dq_oe_o,
    output ddr3_pkg::dqs_t          dqs_o,
    output logic                    dqs_oe_o,
    input  wire ddr3_pkg::dq_t      dq_i
);

    // Memory clock and strobes come straight from the clocks
    assign ddr3_ck_o = clk_i;
    assign dqs_o     = {$bits(ddr3_pkg::dqs_t){clk_ddr_i}};

    ddr3_cmd_path u_cmd_path
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .dfi_cke_i      (dfi_cke_i),
        .dfi_reset_n_i  (dfi_reset_n_i),
        .dfi_ras_n_i    (dfi_ras_n_i),
        .dfi_cas_n_i    (dfi_cas_n_i),
        .dfi_we_n_i     (dfi_we_n_i),
        .dfi_cs_n_i     (dfi_cs_n_i),
        .dfi_odt_i      (dfi_odt_i),
        .dfi_bank_i     (dfi_bank_i),
        .dfi_address_i  (dfi_address_i),
        .ddr3_cke_o     (ddr3_cke_o),
        .ddr3_reset_n_o (ddr3_reset_n_o),
        .ddr3_ras_n_o   (ddr3_ras_n_o),
        .ddr3_cas_n_o   (ddr3_cas_n_o),
        .ddr3_we_n_o    (ddr3_we_n_o),
        .ddr3_cs_n_o    (ddr3_cs_n_o),
        .ddr3_odt_o     (ddr3_odt_o),
        .ddr3_ba_o      (ddr3_ba_o),
        .ddr3_addr_o    (ddr3_addr_o)
    );

    ddr3_write_path u_write_path
    (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .dfi_wrdata_i      (dfi_wrdata_i),
        .dfi_wrdata_mask_i (dfi_wrdata_mask_i),
        .dfi_wrdata_en_i   (dfi_wrdata_en_i),
        .dq_o              (dq_o),
        .dm_o              (dm_o),
        .dq_oe_o           (dq_oe_o),
        .dqs_oe_o          (dqs_oe_o)
    );

    ddr3_read_path u_read_path
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dq_i         (dq_i),
        .dfi_rddata_o (dfi_rddata_o)
    );

    ddr3_rd_valid_sched u_rd_valid_sched
    (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .cfg_valid_i        (cfg_valid_i),
        .cfg_i              (cfg_i),
        .dfi_rddata_en_i    (dfi_rddata_en_i),
        .dfi_rddata_valid_o (dfi_rddata_valid_o)
    );

endmodule

`default_nettype wire

// ==== tb_ddr3_phy.sv ====
// Directed testbench for the DDR3 PHY top level
// Acts as both the DFI controller and the memory; dq_i is driven on both edges
// Timing offsets count from the rising edge where the testbench drives an input

`timescale 1ns/10ps
`default_nettype none

`include "ddr3_phy_defines.svh"

module tb_ddr3_phy;

    localparam int CLK_PERIOD = 40;
    localparam int CMD_N = 8;
    localparam int CAP_N = 12;
    // Config write, 16 enable slots, worst latency, drain
    localparam int SCHED_CYCLES = 2 + 16 + 11 + 2;
    localparam int TEST_CYCLES = 4 + 1 + 2 * CMD_N + 9 + 6 + (CAP_N + 1) + 6 * SCHED_CYCLES;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

    logic clk_i = 1'b0;
    logic clk_ddr_i;
    logic rst_i;
    logic cfg_valid_i;
    dfi_pkg::phy_cfg_t cfg_i;
    logic dfi_cke_i, dfi_reset_n_i, dfi_ras_n_i, dfi_cas_n_i;
    logic dfi_we_n_i, dfi_cs_n_i, dfi_odt_i;
    dfi_pkg::dfi_bank_t dfi_bank_i;
    dfi_pkg::dfi_addr_t dfi_address_i;
    dfi_pkg::dfi_data_t dfi_wrdata_i;
    dfi_pkg::dfi_mask_t dfi_wrdata_mask_i;
    logic dfi_wrdata_en_i;
    logic dfi_rddata_en_i;
    dfi_pkg::dfi_data_t dfi_rddata_o;
    logic dfi_rddata_valid_o;
    logic ddr3_ck_o, ddr3_cke_o, ddr3_reset_n_o, ddr3_ras_n_o, ddr3_cas_n_o;
    logic ddr3_we_n_o, ddr3_cs_n_o, ddr3_odt_o;
    dfi_pkg::dfi_bank_t ddr3_ba_o;
    dfi_pkg::dfi_addr_t ddr3_addr_o;
    ddr3_pkg::dq_t dq_o;
    ddr3_pkg::dm_t dm_o;
    logic dq_oe_o;
    ddr3_pkg::dqs_t dqs_o;
    logic dqs_oe_o;
    ddr3_pkg::dq_t dq_i;
    int seed = 32'hbffd_699a;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Quarter-period shifted copy of clk_i
    initial
    begin
        clk_ddr_i = 1'b0;
        #(CLK_PERIOD / 4);
        forever #(CLK_PERIOD / 2) clk_ddr_i = ~clk_ddr_i;
    end

    ddr3_phy_top u_ddr3_phy_top
    (
        .clk_i (clk_i), .clk_ddr_i (clk_ddr_i), .rst_i (rst_i),
        .cfg_valid_i (cfg_valid_i), .cfg_i (cfg_i),
        .dfi_cke_i (dfi_cke_i), .dfi_reset_n_i (dfi_reset_n_i),
        .dfi_ras_n_i (dfi_ras_n_i), .dfi_cas_n_i (dfi_cas_n_i),
        .dfi_we_n_i (dfi_we_n_i), .dfi_cs_n_i (dfi_cs_n_i), .dfi_odt_i (dfi_odt_i),
        .dfi_bank_i (dfi_bank_i), .dfi_address_i (dfi_address_i),
        .dfi_wrdata_i (dfi_wrdata_i), .dfi_wrdata_mask_i (dfi_wrdata_mask_i),
        .dfi_wrdata_en_i (dfi_wrdata_en_i), .dfi_rddata_en_i (dfi_rddata_en_i),
        .dfi_rddata_o (dfi_rddata_o), .dfi_rddata_valid_o (dfi_rddata_valid_o),
        .ddr3_ck_o (ddr3_ck_o), .ddr3_cke_o (ddr3_cke_o), .ddr3_reset_n_o (ddr3_reset_n_o),
        .ddr3_ras_n_o (ddr3_ras_n_o), .ddr3_cas_n_o (ddr3_cas_n_o),
        .ddr3_we_n_o (ddr3_we_n_o), .ddr3_cs_n_o (ddr3_cs_n_o), .ddr3_odt_o (ddr3_odt_o),
        .ddr3_ba_o (ddr3_ba_o), .ddr3_addr_o (ddr3_addr_o),
        .dq_o (dq_o), .dm_o (dm_o), .dq_oe_o (dq_oe_o),
        .dqs_o (dqs_o), .dqs_oe_o (dqs_oe_o), .dq_i (dq_i)
    );

    // ------------------------------------------------------------------------
    // Compare tasks, one per result type
    // ------------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_data(input string name, input dfi_pkg::dfi_data_t exp,
                              input dfi_pkg::dfi_data_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_dq(input string name, input ddr3_pkg::dq_t exp, input ddr3_pkg::dq_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_dm(input string name, input ddr3_pkg::dm_t exp, input ddr3_pkg::dm_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_dqs(input string name, input ddr3_pkg::dqs_t exp,
                             input ddr3_pkg::dqs_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input dfi_pkg::dfi_addr_t exp,
                              input dfi_pkg::dfi_addr_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bank(input string name, input dfi_pkg::dfi_bank_t exp,
                              input dfi_pkg::dfi_bank_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic check_reset_state();
        @(negedge clk_i);
        check_bit("ddr3_cke_o", 1'b0, ddr3_cke_o);
        check_bit("ddr3_reset_n_o", 1'b0, ddr3_reset_n_o);
        check_bit("ddr3_ras_n_o", 1'b0, ddr3_ras_n_o);
        check_bit("ddr3_cas_n_o", 1'b0, ddr3_cas_n_o);
        check_bit("ddr3_we_n_o", 1'b0, ddr3_we_n_o);
        check_bit("ddr3_cs_n_o", 1'b0, ddr3_cs_n_o);
        check_bit("ddr3_odt_o", 1'b0, ddr3_odt_o);
        check_bank("ddr3_ba_o", '0, ddr3_ba_o);
        check_addr("ddr3_addr_o", '0, ddr3_addr_o);
        check_bit("dfi_rddata_valid_o", 1'b0, dfi_rddata_valid_o);
        check_bit("dq_oe_o", 1'b0, dq_oe_o);
        check_bit("dqs_oe_o", 1'b0, dqs_oe_o);
    endtask

    // Memory clock follows clk_i and the strobes lag it by a quarter period
    task automatic check_clock_pins();
        @(posedge clk_i);
        #5;
        check_bit("ddr3_ck_o", 1'b1, ddr3_ck_o);
        check_dqs("dqs_o", '0, dqs_o);
        #10;
        check_bit("ddr3_ck_o", 1'b1, ddr3_ck_o);
        check_dqs("dqs_o", '1, dqs_o);
        #10;
        check_bit("ddr3_ck_o", 1'b0, ddr3_ck_o);
        check_dqs("dqs_o", '1, dqs_o);
        #10;
        check_bit("ddr3_ck_o", 1'b0, ddr3_ck_o);
        check_dqs("dqs_o", '0, dqs_o);
    endtask

    // Pins follow one edge after the edge that samples the command
    task automatic run_cmd_test(input int n);
        dfi_pkg::dfi_addr_t addr_v;
        dfi_pkg::dfi_bank_t bank_v;
        logic [6:0] ctl_v;
        for (int i = 0; i < n; i++)
        begin
            addr_v = dfi_pkg::dfi_addr_t'($random(seed));
            bank_v = dfi_pkg::dfi_bank_t'($random(seed));
            ctl_v = 7'($random(seed));
            @(posedge clk_i);
            {dfi_cke_i, dfi_reset_n_i, dfi_ras_n_i, dfi_cas_n_i,
             dfi_we_n_i, dfi_cs_n_i, dfi_odt_i} <= ctl_v;
            dfi_bank_i <= bank_v;
            dfi_address_i <= addr_v;
            @(posedge clk_i);
            #10;
            check_bit("ddr3_cke_o", ctl_v[6], ddr3_cke_o);
            check_bit("ddr3_reset_n_o", ctl_v[5], ddr3_reset_n_o);
            check_bit("ddr3_ras_n_o", ctl_v[4], ddr3_ras_n_o);
            check_bit("ddr3_cas_n_o", ctl_v[3], ddr3_cas_n_o);
            check_bit("ddr3_we_n_o", ctl_v[2], ddr3_we_n_o);
            check_bit("ddr3_cs_n_o", ctl_v[1], ddr3_cs_n_o);
            check_bit("ddr3_odt_o", ctl_v[0], ddr3_odt_o);
            check_bank("ddr3_ba_o", bank_v, ddr3_ba_o);
            check_addr("ddr3_addr_o", addr_v, ddr3_addr_o);
        end
    endtask

    // Word driven in cycle c is on the pins in cycle c+2, enables on in cycles 3..k+3
    task automatic run_write_burst(input int k);
        dfi_pkg::dfi_data_t words [0:15];
        dfi_pkg::dfi_mask_t masks [0:15];
        for (int c = 0; c <= k + 4; c++)
        begin
            @(posedge clk_i);
            if (c < k)
            begin
                words[c] = dfi_pkg::dfi_data_t'($random(seed));
                masks[c] = dfi_pkg::dfi_mask_t'($random(seed));
                dfi_wrdata_i <= words[c];
                dfi_wrdata_mask_i <= masks[c];
            end
            dfi_wrdata_en_i <= (c < k);
            #10;
            check_bit("dq_oe_o", (c >= 3 && c <= k + 3), dq_oe_o);
            check_bit("dqs_oe_o", (c >= 3 && c <= k + 3), dqs_oe_o);
            if (c >= 2 && c < k + 2)
            begin
                // High phase carries the upper halves
                check_dq("dq_o", words[c - 2][`DFI_DATA_W-1 -: `DDR3_DQ_W], dq_o);
                check_dm("dm_o", masks[c - 2][`DFI_MASK_W-1 -: `DDR3_DM_W], dm_o);
                #20;
                check_dq("dq_o", words[c - 2][`DDR3_DQ_W-1:0], dq_o);
                check_dm("dm_o", masks[c - 2][`DDR3_DM_W-1:0], dm_o);
            end
        end
    endtask

    task automatic run_read_capture(input int n);
        ddr3_pkg::dq_t rise_v [0:31];
        ddr3_pkg::dq_t fall_v [0:31];
        for (int i = 0; i <= n; i++)
        begin
            @(posedge clk_i);
            if (i < n)
            begin
                rise_v[i] = ddr3_pkg::dq_t'($random(seed));
                dq_i <= rise_v[i];
            end
            if (i > 0)
            begin
                // Beat present at this edge on top, beat from the falling edge below
                #10;
                check_data("dfi_rddata_o", {fall_v[i - 1], rise_v[i - 1]}, dfi_rddata_o);
            end
            if (i < n)
            begin
                @(negedge clk_i);
                fall_v[i] = ddr3_pkg::dq_t'($random(seed));
                dq_i <= fall_v[i];
            end
        end
    endtask

    task automatic set_rd_latency(input dfi_pkg::rd_lat_t lat);
        dfi_pkg::phy_cfg_t cfg_v;
        cfg_v = dfi_pkg::phy_cfg_t'($random(seed));
        cfg_v[`PHY_CFG_RDLAT_MSB:`PHY_CFG_RDLAT_LSB] = lat;
        @(posedge clk_i);
        cfg_valid_i <= 1'b1;
        cfg_i <= cfg_v;
        @(posedge clk_i);
        cfg_valid_i <= 1'b0;
    endtask

    // Bit c of en_map drives a read enable in cycle c; valid due in cycle c+1+lat
    task automatic run_read_valid(input int lat, input logic [15:0] en_map);
        int o;
        logic exp_v;
        for (int c = 0; c <= 17 + lat; c++)
        begin
            @(posedge clk_i);
            dfi_rddata_en_i <= (c < 16) ? en_map[c] : 1'b0;
            #10;
            o = c - 1 - lat;
            exp_v = (o >= 0 && o < 16) ? en_map[o] : 1'b0;
            check_bit("dfi_rddata_valid_o", exp_v, dfi_rddata_valid_o);
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        stop_with_failure();
    end

    initial
    begin
        rst_i = 1'b1;
        // Active inputs during reset must not reach any output
        cfg_valid_i = 1'b1;
        cfg_i = '0;
        {dfi_cke_i, dfi_reset_n_i, dfi_ras_n_i, dfi_cas_n_i} = 4'b1111;
        {dfi_we_n_i, dfi_cs_n_i, dfi_odt_i} = 3'b111;
        dfi_bank_i = '1;
        dfi_address_i = '1;
        dfi_wrdata_i = '0;
        dfi_wrdata_mask_i = '0;
        dfi_wrdata_en_i = 1'b1;
        dfi_rddata_en_i = 1'b1;
        dq_i = '0;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        cfg_valid_i <= 1'b0;
        {dfi_cke_i, dfi_reset_n_i, dfi_ras_n_i, dfi_cas_n_i} <= 4'b0000;
        {dfi_we_n_i, dfi_cs_n_i, dfi_odt_i} <= 3'b000;
        dfi_bank_i <= '0;
        dfi_address_i <= '0;
        dfi_wrdata_en_i <= 1'b0;
        dfi_rddata_en_i <= 1'b0;
        check_reset_state();
        check_clock_pins();
        // Latency after reset is 4
        run_read_valid(4, 16'h0001);
        run_cmd_test(CMD_N);
        run_write_burst(4);
        run_write_burst(1);
        run_read_capture(CAP_N);
        set_rd_latency(0);
        run_read_valid(0, 16'h0011);
        set_rd_latency(7);
        run_read_valid(7, 16'h0011);
        set_rd_latency(11);
        run_read_valid(11, 16'h0011);
        // Several reads in flight, back to back and with gaps
        set_rd_latency(3);
        run_read_valid(3, 16'h0B27);
        set_rd_latency(11);
        run_read_valid(11, 16'h8C0F);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
dfi_pkg.sv
ddr3_pkg.sv
ddr3_cmd_path.sv
ddr_out_lane.sv
ddr3_write_path.sv
ddr3_read_path.sv
ddr3_rd_valid_sched.sv
ddr3_phy_top.sv
tb_ddr3_phy.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the DDR3 PHY testbench with Verilator.
# Run from the project root. Exit status is non-zero on any failure.

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
    -f sources.f --top-module tb_ddr3_phy -o tb_ddr3_phy_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_ddr3_phy_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

exit 0
